//--- l2tlb.f
logic/l2tlb_pkg.sv
logic/tlb_port_if.sv
logic/tlb_array.sv
logic/pte_walker.sv
logic/l2tlb.sv
dv/clk_gen.sv
dv/l2tlb_props.sv
dv/tb_l2tlb.sv

//--- Makefile
SIM  := obj_dir/Vtb_l2tlb
SRCS := $(shell grep -v '^+' l2tlb.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }

$(SIM): l2tlb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_l2tlb -f l2tlb.f

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_l2tlb.sv
`default_nettype none

module tb_l2tlb;
    timeunit 1ns;
    timeprecision 100ps;
    import l2tlb_pkg::*;

    localparam int   N_ITER      = 40;
    localparam int   CYCLE_LIMIT = 200 * 5 * N_ITER;
    localparam ppn_t ROOT_PPN    = 44'h1000;

    logic clk, rst_n;
    asid_t satp_asid;
    ppn_t satp_ppn;
    logic sflush_vma_valid, immu_miss_valid, immu_miss_ready, dmmu_miss_valid, dmmu_miss_ready;
    vaddr_t vaddr_i, vaddr_d;
    logic mmu_arvalid, mmu_arready, mmu_rvalid, pte_valid, pte_ready, pte_error;
    paddr_t mmu_araddr;
    logic [1:0] mmu_rresp;
    pte_t mmu_rdata;
    tlb_entry_t pte;

    pte_t        mem [paddr_t];
    bit          bad_addr [paddr_t];
    int          ar_count = 0;
    logic [15:0] lfsr_state = 16'd43205;

    clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    l2tlb uut (
        .clk(clk), .rst_n(rst_n), .satp_asid(satp_asid), .satp_ppn(satp_ppn),
        .sflush_vma_valid(sflush_vma_valid),
        .immu_miss_valid(immu_miss_valid), .immu_miss_ready(immu_miss_ready), .vaddr_i(vaddr_i),
        .dmmu_miss_valid(dmmu_miss_valid), .dmmu_miss_ready(dmmu_miss_ready), .vaddr_d(vaddr_d),
        .mmu_arvalid(mmu_arvalid), .mmu_arready(mmu_arready), .mmu_araddr(mmu_araddr),
        .mmu_rvalid(mmu_rvalid), .mmu_rresp(mmu_rresp), .mmu_rdata(mmu_rdata),
        .pte_valid(pte_valid), .pte_ready(pte_ready), .pte(pte), .pte_error(pte_error)
    );

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[62:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "check %s mismatch", name);
        end
    endtask

    task automatic check_result(input string name, input tlb_entry_t exp, input logic exp_err,
                                input tlb_entry_t got, input logic got_err);
        check_value({name, " error"}, 128'(exp_err), 128'(got_err));
        if (!exp_err) begin
            check_value({name, " entry"}, exp, got);
        end
    endtask

    // ************************************************************
    // page tables and reference walk
    // ************************************************************
    task automatic put_entry(input ppn_t table_ppn, input vpn_part_t idx, input int level,
                             input ppn_t child);
        paddr_t     a;
        pte_t       e;
        ppn_t       leaf;
        logic [3:0] kind;
        a    = {8'h0, table_ppn, idx, 3'h0};
        kind = 4'(rand_bits(4));
        leaf = 44'(rand_bits(44));
        if (level == 2) leaf[17:0] = '0;
        if (level == 1) leaf[8:0] = '0;
        e                           = '0;
        e[9:0]                      = 10'(rand_bits(10));
        e[PTE_V]                    = 1'b1;
        e[PTE_R]                    = 1'b1;
        e[PTE_A]                    = 1'b1;
        e[PTE_PPN_LSB +: $bits(ppn_t)] = leaf;
        if (kind < 4'd6) begin
            // pointer entry that faults at L0
            e[PTE_R]                       = 1'b0;
            e[PTE_W]                       = 1'b0;
            e[PTE_X]                       = 1'b0;
            e[PTE_PPN_LSB +: $bits(ppn_t)] = child;
        end else if (kind == 4'd12) begin
            e[PTE_V] = 1'b0;
        end else if (kind == 4'd13) begin
            e[PTE_R] = 1'b0;
            e[PTE_W] = 1'b1;
        end else if (kind == 4'd14) begin
            e[PTE_A] = 1'b0;
        end else if (kind == 4'd15) begin
            if (level > 0) e[PTE_PPN_LSB] = 1'b1;
            else e[60] = 1'b1;
        end
        mem[a] = e;
        if (rand_bits(4) == 64'd0) bad_addr[a] = 1'b1;
    endtask

    task automatic build_tables();
        for (int i = 0; i < 4; i++) begin
            put_entry(ROOT_PPN, 9'(i), 2, 44'h2000 + 44'(i));
            for (int j = 0; j < 4; j++) begin
                put_entry(44'h2000 + 44'(i), 9'(j), 1, 44'h3000 + 44'(i * 4 + j));
                for (int k = 0; k < 8; k++) begin
                    put_entry(44'h3000 + 44'(i * 4 + j), 9'(k), 0, '0);
                end
            end
        end
    endtask

    task automatic model_walk(input vaddr_t va, input asid_t asid,
                              output tlb_entry_t exp, output logic err);
        ppn_t       ppn;
        paddr_t     a;
        pte_t       e;
        logic       done;
        logic [2:0] size;
        exp  = '0;
        err  = 1'b0;
        done = 1'b0;
        ppn  = satp_ppn;
        if (va[63:39] != {25{va[38]}}) begin
            err = 1'b1;
            return;
        end
        for (int lvl = 2; lvl >= 0 && !done; lvl--) begin
            a    = {8'h0, ppn, va[12 + 9 * lvl +: 9], 3'h0};
            e    = mem.exists(a) ? mem[a] : '0;
            done = 1'b1;
            // size code 2 for 1G, 1 for 2M, 0 for 4K
            size = 3'(lvl);
            if (bad_addr.exists(a) || e[63:54] != 10'd0 || !e[PTE_V] || (!e[PTE_R] && e[PTE_W]))
                err = 1'b1;
            else if (!e[PTE_R] && !e[PTE_W] && !e[PTE_X]) begin
                err  = (lvl == 0);
                done = (lvl == 0);
                ppn  = e[53:10];
            end else if ((lvl == 2 && e[27:10] != 18'd0) || (lvl == 1 && e[18:10] != 9'd0))
                err = 1'b1;
            else if (!e[PTE_A])
                err = 1'b1;
            else
                exp = {asid, e[53:10], e[9:0], va[38:12], 28'h0, size};
        end
    endtask

    function automatic vaddr_t random_vaddr();
        vaddr_t va;
        va        = '0;
        va[11:0]  = 12'(rand_bits(12));
        va[20:12] = 9'(rand_bits(3));
        va[29:21] = 9'(rand_bits(2));
        va[38:30] = 9'(rand_bits(3));
        // bit 38 is always 0 here
        if (rand_bits(3) == 64'd0) va[63:39] = 25'(rand_bits(25)) | 25'd1;
        return va;
    endfunction

    // ************************************************************
    // memory read channel
    // ************************************************************
    initial begin : memory_model
        logic   fire;
        logic   pending;
        int     wait_cnt;
        paddr_t rd_addr;
        mmu_arready = 1'b0;
        mmu_rvalid  = 1'b0;
        mmu_rresp   = 2'b00;
        mmu_rdata   = '0;
        pending     = 1'b0;
        wait_cnt    = 0;
        rd_addr     = '0;
        forever begin
            @(posedge clk);
            fire = mmu_arvalid & mmu_arready;
            if (fire) begin
                ar_count++;
                rd_addr = mmu_araddr;
            end
            #1;
            mmu_rvalid = 1'b0;
            if (fire) begin
                pending  = 1'b1;
                wait_cnt = 1 + int'(rand_bits(2));
            end else if (pending) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    pending    = 1'b0;
                    mmu_rvalid = 1'b1;
                    mmu_rdata  = mem.exists(rd_addr) ? mem[rd_addr] : '0;
                    mmu_rresp  = bad_addr.exists(rd_addr) ? 2'b10 : 2'b00;
                end
            end
            mmu_arready = mmu_arvalid ? 1'(rand_bits(1)) : 1'b0;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
        $display("=== FAIL ===");
        $fatal(1, "simulation timeout");
    end

    // ************************************************************
    // request and response tasks
    // ************************************************************
    task automatic send(input logic is_d, input vaddr_t va);
        if (is_d) begin
            dmmu_miss_valid = 1'b1;
            vaddr_d         = va;
        end else begin
            immu_miss_valid = 1'b1;
            vaddr_i         = va;
        end
    endtask

    task automatic wait_accept(input logic is_d);
        logic fired;
        fired = 1'b0;
        while (!fired) begin
            @(posedge clk);
            fired = is_d ? (dmmu_miss_valid & dmmu_miss_ready)
                         : (immu_miss_valid & immu_miss_ready);
            #1;
        end
        if (is_d) dmmu_miss_valid = 1'b0;
        else immu_miss_valid = 1'b0;
    endtask

    // lat counts edges from acceptance to pte_valid
    task automatic collect(input int hold, output tlb_entry_t entry, output logic err,
                           output int lat);
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!pte_valid);
        entry = pte;
        err   = pte_error;
        for (int h = 0; h < hold; h++) begin
            #1;
            @(posedge clk);
            check_value("hold pte_valid", 128'd1, 128'(pte_valid));
            check_value("hold pte", entry, pte);
            check_value("hold pte_error", 128'(err), 128'(pte_error));
            check_value("hold immu ready", 128'd0, 128'(immu_miss_ready));
            check_value("hold dmmu ready", 128'd0, 128'(dmmu_miss_ready));
        end
        #1;
        pte_ready = 1'b1;
        @(posedge clk);
        #1;
        pte_ready = 1'b0;
    endtask

    task automatic translate(input logic is_d, input vaddr_t va, input int hold,
                             output tlb_entry_t entry, output logic err, output int lat,
                             output int reads);
        int ar_start;
        ar_start = ar_count;
        send(is_d, va);
        wait_accept(is_d);
        collect(hold, entry, err, lat);
        reads = ar_count - ar_start;
    endtask

    task automatic flush_tlb(input asid_t new_asid);
        sflush_vma_valid = 1'b1;
        satp_asid        = new_asid;
        @(posedge clk);
        #1;
        sflush_vma_valid = 1'b0;
    endtask

    task automatic dual_request(input vaddr_t va_i, input vaddr_t va_d, input int hold);
        tlb_entry_t exp, got;
        logic       exp_err, got_err;
        int         lat;
        send(1'b0, va_i);
        send(1'b1, va_d);
        @(posedge clk);
        check_value("dual immu accepted", 128'd1, 128'(immu_miss_ready));
        check_value("dual dmmu held off", 128'd0, 128'(dmmu_miss_ready));
        #1;
        immu_miss_valid = 1'b0;
        model_walk(va_i, satp_asid, exp, exp_err);
        collect(hold, got, got_err, lat);
        check_result("dual immu", exp, exp_err, got, got_err);
        // first edge after the response handshake
        @(posedge clk);
        check_value("dual dmmu accepted", 128'd1, 128'(dmmu_miss_ready));
        #1;
        dmmu_miss_valid = 1'b0;
        model_walk(va_d, satp_asid, exp, exp_err);
        collect(0, got, got_err, lat);
        check_result("dual dmmu", exp, exp_err, got, got_err);
    endtask

    // ************************************************************
    // test sequence
    // ************************************************************
    initial begin : stimulus
        tlb_entry_t exp, got;
        logic       exp_err, got_err, is_d;
        int         lat, reads, hold;
        vaddr_t     va, va2;
        satp_ppn         = ROOT_PPN;
        satp_asid        = 16'(rand_bits(16));
        sflush_vma_valid = 1'b0;
        immu_miss_valid  = 1'b0;
        dmmu_miss_valid  = 1'b0;
        vaddr_i          = '0;
        vaddr_d          = '0;
        pte_ready        = 1'b0;
        build_tables();
        @(posedge rst_n);
        @(posedge clk);
        #1;
        for (int n = 0; n < N_ITER; n++) begin
            is_d = 1'(rand_bits(1));
            va   = random_vaddr();
            hold = int'(rand_bits(2));
            model_walk(va, satp_asid, exp, exp_err);
            translate(is_d, va, hold, got, got_err, lat, reads);
            check_result("random", exp, exp_err, got, got_err);
            if (va[63:39] != {25{va[38]}}) begin
                check_value("non-canonical reads", 128'd0, 128'(reads));
                check_value("non-canonical latency", 128'd1, 128'(lat));
            end else if (!exp_err && exp[2:0] == 3'd0) begin
                translate(~is_d, va, 0, got, got_err, lat, reads);
                check_result("repeat", exp, exp_err, got, got_err);
                check_value("repeat reads", 128'd0, 128'(reads));
                check_value("repeat latency", 128'd2, 128'(lat));
                if (rand_bits(1) == 64'd1) begin
                    // with the asid kept only the flush forces the walk
                    if (rand_bits(1) == 64'd1) begin
                        flush_tlb(16'(rand_bits(16)));
                    end else begin
                        flush_tlb(satp_asid);
                    end
                    model_walk(va, satp_asid, exp, exp_err);
                    translate(is_d, va, 0, got, got_err, lat, reads);
                    check_result("after flush", exp, exp_err, got, got_err);
                    check_value("after flush reads", 128'd3, 128'(reads));
                end
            end
            if (rand_bits(2) == 64'd0) begin
                va   = random_vaddr();
                va2  = random_vaddr();
                hold = int'(rand_bits(2));
                dual_request(va, va2, hold);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/l2tlb_props.sv
`default_nettype none

module l2tlb_props (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  immu_miss_valid,
    input  logic                  dmmu_miss_ready,
    input  logic                  mmu_arvalid,
    input  logic                  mmu_arready,
    input  l2tlb_pkg::paddr_t     mmu_araddr,
    input  logic                  pte_valid,
    input  logic                  pte_ready,
    input  l2tlb_pkg::tlb_entry_t pte,
    input  logic                  pte_error
);
    timeunit 1ns;
    timeprecision 100ps;

    // ************************************************************
    // handshake stability
    // ************************************************************
    // payload of an error response carries no meaning
    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (pte_valid && !pte_ready) |=>
            (pte_valid && $stable(pte_error) && (pte_error || $stable(pte))))
        else $error("response dropped or changed before pte_ready");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mmu_arvalid && !mmu_arready) |=> (mmu_arvalid && $stable(mmu_araddr)))
        else $error("read address dropped or changed before mmu_arready");

    // instruction side has priority
    arb_order: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmmu_miss_ready && immu_miss_valid))
        else $error("data side ready while instruction side requests");

    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !pte_valid)
        else $error("response valid right after reset");

endmodule

bind l2tlb l2tlb_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .immu_miss_valid (immu_miss_valid),
    .dmmu_miss_ready (dmmu_miss_ready),
    .mmu_arvalid     (mmu_arvalid),
    .mmu_arready     (mmu_arready),
    .mmu_araddr      (mmu_araddr),
    .pte_valid       (pte_valid),
    .pte_ready       (pte_ready),
    .pte             (pte),
    .pte_error       (pte_error)
);

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after the third edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/l2tlb.sv
`default_nettype none

module l2tlb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l2tlb_pkg::asid_t        satp_asid,
    input  l2tlb_pkg::ppn_t         satp_ppn,
    input  logic                    sflush_vma_valid,
    input  logic                    immu_miss_valid,
    output logic                    immu_miss_ready,
    input  l2tlb_pkg::vaddr_t       vaddr_i,
    input  logic                    dmmu_miss_valid,
    output logic                    dmmu_miss_ready,
    input  l2tlb_pkg::vaddr_t       vaddr_d,
    output logic                    mmu_arvalid,
    input  logic                    mmu_arready,
    output l2tlb_pkg::paddr_t       mmu_araddr,
    input  logic                    mmu_rvalid,
    input  logic [1:0]              mmu_rresp,
    input  l2tlb_pkg::pte_t         mmu_rdata,
    output logic                    pte_valid,
    input  logic                    pte_ready,
    output l2tlb_pkg::tlb_entry_t   pte,
    output logic                    pte_error
);

    tlb_port_if tp ();

    // walker owns the request and the memory channel
    pte_walker u_walker (
        .clk             (clk),
        .rst_n           (rst_n),
        .satp_asid       (satp_asid),
        .satp_ppn        (satp_ppn),
        .immu_miss_valid (immu_miss_valid),
        .immu_miss_ready (immu_miss_ready),
        .vaddr_i         (vaddr_i),
        .dmmu_miss_valid (dmmu_miss_valid),
        .dmmu_miss_ready (dmmu_miss_ready),
        .vaddr_d         (vaddr_d),
        .mmu_arvalid     (mmu_arvalid),
        .mmu_arready     (mmu_arready),
        .mmu_araddr      (mmu_araddr),
        .mmu_rvalid      (mmu_rvalid),
        .mmu_rresp       (mmu_rresp),
        .mmu_rdata       (mmu_rdata),
        .pte_valid       (pte_valid),
        .pte_ready       (pte_ready),
        .pte             (pte),
        .pte_error       (pte_error),
        .tp              (tp.walker)
    );

    tlb_array u_array (
        .clk              (clk),
        .rst_n            (rst_n),
        .sflush_vma_valid (sflush_vma_valid),
        .satp_asid        (satp_asid),
        .tp               (tp.array)
    );

endmodule

`default_nettype wire

//--- logic/pte_walker.sv
`default_nettype none

module pte_walker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l2tlb_pkg::asid_t        satp_asid,
    input  l2tlb_pkg::ppn_t         satp_ppn,
    input  logic                    immu_miss_valid,
    output logic                    immu_miss_ready,
    input  l2tlb_pkg::vaddr_t       vaddr_i,
    input  logic                    dmmu_miss_valid,
    output logic                    dmmu_miss_ready,
    input  l2tlb_pkg::vaddr_t       vaddr_d,
    output logic                    mmu_arvalid,
    input  logic                    mmu_arready,
    output l2tlb_pkg::paddr_t       mmu_araddr,
    input  logic                    mmu_rvalid,
    input  logic [1:0]              mmu_rresp,
    input  l2tlb_pkg::pte_t         mmu_rdata,
    output logic                    pte_valid,
    input  logic                    pte_ready,
    output l2tlb_pkg::tlb_entry_t   pte,
    output logic                    pte_error,
    tlb_port_if.walker              tp
);
    import l2tlb_pkg::*;

    walk_state_t state_q;
    vaddr_t      vaddr_q;
    logic        arvalid_q;
    ppn_t        ar_ppn_q;
    vpn_part_t   ar_idx_q;
    tlb_entry_t  pte_q;
    logic        err_q;
    logic        refill_q;

    logic        immu_fire;
    logic        dmmu_fire;
    logic        req_fire;
    vaddr_t      req_vaddr;
    logic        non_canon;
    logic        in_walk;
    logic        rd_take;
    ppn_t        rd_ppn;
    logic        pte_is_table;
    logic        leaf_misaligned;
    logic        pte_fault;
    logic [2:0]  leaf_size;
    vpn_part_t   next_idx;
    tlb_entry_t  leaf_entry;

    // ************************************************************
    // request arbitration with the instruction side first
    // ************************************************************
    assign immu_miss_ready = (state_q == IDLE);
    assign dmmu_miss_ready = (state_q == IDLE) & ~immu_miss_valid;
    assign immu_fire       = immu_miss_valid & immu_miss_ready;
    assign dmmu_fire       = dmmu_miss_valid & dmmu_miss_ready;
    assign req_fire        = immu_fire | dmmu_fire;
    assign req_vaddr       = immu_fire ? vaddr_i : vaddr_d;
    assign non_canon       = req_vaddr[63:39] != {25{req_vaddr[38]}};

    // ************************************************************
    // pte checks
    // ************************************************************
    assign in_walk      = (state_q == WALK_L2) | (state_q == WALK_L1) | (state_q == WALK_L0);
    // read data only counts once the address went out
    assign rd_take      = in_walk & ~arvalid_q & mmu_rvalid;
    assign rd_ppn       = mmu_rdata[PTE_PPN_LSB +: $bits(ppn_t)];
    assign pte_is_table = ~mmu_rdata[PTE_R] & ~mmu_rdata[PTE_W] & ~mmu_rdata[PTE_X];

    always_comb begin
        leaf_size       = PAGE_4K;
        next_idx        = vaddr_q[20:12];
        leaf_misaligned = 1'b0;
        case (state_q)
            WALK_L2: begin
                leaf_size       = PAGE_1G;
                next_idx        = vaddr_q[29:21];
                leaf_misaligned = |rd_ppn[17:0];
            end
            WALK_L1: begin
                leaf_size       = PAGE_2M;
                leaf_misaligned = |rd_ppn[8:0];
            end
            default: begin
            end
        endcase
    end

    // a table at L0 faults and a leaf needs alignment and A set
    assign pte_fault = (mmu_rresp != 2'b00)
                     | (|mmu_rdata[63:54])
                     | ~mmu_rdata[PTE_V]
                     | (~mmu_rdata[PTE_R] & mmu_rdata[PTE_W])
                     | (pte_is_table ? (state_q == WALK_L0)
                                     : (leaf_misaligned | ~mmu_rdata[PTE_A]));

    assign leaf_entry = {satp_asid, rd_ppn, mmu_rdata[9:0], vaddr_q[38:12], 28'h0, leaf_size};

    // ************************************************************
    // walk fsm
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            arvalid_q <= 1'b0;
            err_q     <= 1'b0;
            refill_q  <= 1'b0;
        end else begin
            refill_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_fire) begin
                        state_q <= non_canon ? RESPOND : SEARCH;
                        err_q   <= non_canon;
                    end
                end
                SEARCH: begin
                    if (tp.hit) begin
                        state_q <= RESPOND;
                        err_q   <= 1'b0;
                    end else begin
                        state_q   <= WALK_L2;
                        arvalid_q <= 1'b1;
                    end
                end
                WALK_L2, WALK_L1, WALK_L0: begin
                    if (arvalid_q) begin
                        if (mmu_arready) begin
                            arvalid_q <= 1'b0;
                        end
                    end else if (rd_take) begin
                        if (pte_fault) begin
                            state_q <= RESPOND;
                            err_q   <= 1'b1;
                        end else if (pte_is_table) begin
                            state_q   <= (state_q == WALK_L2) ? WALK_L1 : WALK_L0;
                            arvalid_q <= 1'b1;
                        end else begin
                            state_q  <= RESPOND;
                            err_q    <= 1'b0;
                            refill_q <= (state_q == WALK_L0);
                        end
                    end
                end
                RESPOND: begin
                    if (pte_ready) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request, read address and response payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            vaddr_q <= req_vaddr;
        end
        if (state_q == SEARCH) begin
            ar_ppn_q <= satp_ppn;
            ar_idx_q <= vaddr_q[38:30];
        end else if (rd_take & pte_is_table) begin
            ar_ppn_q <= rd_ppn;
            ar_idx_q <= next_idx;
        end
        if ((state_q == SEARCH) & tp.hit) begin
            pte_q <= tp.hit_entry;
        end else if (rd_take & ~pte_fault & ~pte_is_table) begin
            pte_q <= leaf_entry;
        end
    end

    // outputs
    assign mmu_arvalid     = arvalid_q;
    assign mmu_araddr      = {8'h0, ar_ppn_q, ar_idx_q, 3'h0};
    assign pte_valid       = (state_q == RESPOND);
    assign pte             = pte_q;
    assign pte_error       = err_q;
    assign tp.lookup_vpn   = vaddr_q[38:12];
    assign tp.refill       = refill_q;
    assign tp.refill_entry = pte_q;

endmodule

`default_nettype wire

//--- logic/tlb_array.sv
`default_nettype none

module tlb_array (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sflush_vma_valid,
    input  l2tlb_pkg::asid_t   satp_asid,
    tlb_port_if.array          tp
);
    import l2tlb_pkg::*;

    tlb_entry_t          entry_q [TLB_WAYS][TLB_SETS];
    logic [TLB_SETS-1:0] valid_q [TLB_WAYS];
    logic [7:0]          lfsr_q;
    logic                way_sel;
    set_idx_t            lookup_set;
    vpn_t                refill_vpn;
    set_idx_t            refill_set;
    logic [TLB_WAYS-1:0] way_hit;
    tlb_entry_t          hit_entry;

    assign lookup_set = tp.lookup_vpn[$bits(set_idx_t)-1:0];
    assign refill_vpn = tp.refill_entry[ENTRY_VPN_LSB +: $bits(vpn_t)];
    assign refill_set = refill_vpn[$bits(set_idx_t)-1:0];

    // ************************************************************
    // hit detection
    // ************************************************************
    for (genvar w = 0; w < TLB_WAYS; w++) begin : g_way
        tlb_entry_t rd_entry;
        logic       asid_ok;

        assign rd_entry   = entry_q[w][lookup_set];
        assign asid_ok    = (rd_entry[ENTRY_ASID_LSB +: $bits(asid_t)] == satp_asid)
                            | rd_entry[ENTRY_G_BIT];
        assign way_hit[w] = valid_q[w][lookup_set] & asid_ok
                            & (rd_entry[ENTRY_VPN_LSB +: $bits(vpn_t)] == tp.lookup_vpn);
    end

    // at most one way hits in practice
    always_comb begin
        hit_entry = '0;
        for (int w = 0; w < TLB_WAYS; w++) begin
            hit_entry = hit_entry | (entry_q[w][lookup_set] & {$bits(tlb_entry_t){way_hit[w]}});
        end
    end

    assign tp.hit       = |way_hit;
    assign tp.hit_entry = hit_entry;

    // ************************************************************
    // replacement and refill
    // ************************************************************
    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= 8'hA5;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    assign way_sel = lfsr_q[0];

    // flush wins over a refill in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < TLB_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (sflush_vma_valid) begin
            for (int w = 0; w < TLB_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (tp.refill) begin
            valid_q[way_sel][refill_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tp.refill) begin
            entry_q[way_sel][refill_set] <= tp.refill_entry;
        end
    end

endmodule

`default_nettype wire

//--- logic/tlb_port_if.sv
`default_nettype none

interface tlb_port_if;
    import l2tlb_pkg::*;

    // lookup of the stored request
    vpn_t       lookup_vpn;
    logic       hit;
    tlb_entry_t hit_entry;

    // write of a finished 4K walk
    logic       refill;
    tlb_entry_t refill_entry;

    modport walker (
        output lookup_vpn,
        output refill,
        output refill_entry,
        input  hit,
        input  hit_entry
    );

    modport array (
        input  lookup_vpn,
        input  refill,
        input  refill_entry,
        output hit,
        output hit_entry
    );

endinterface

`default_nettype wire

//--- logic/l2tlb_pkg.sv
`default_nettype none

package l2tlb_pkg;

    // ************************************************************
    // widths
    // ************************************************************
    typedef logic [63:0]  vaddr_t;
    typedef logic [63:0]  paddr_t;
    typedef logic [63:0]  pte_t;
    typedef logic [43:0]  ppn_t;
    typedef logic [15:0]  asid_t;
    typedef logic [26:0]  vpn_t;
    typedef logic [8:0]   vpn_part_t;
    typedef logic [2:0]   set_idx_t;

    // asid | ppn | attr | vpn | zeros | size
    // 127    111   67     57    30      2
    typedef logic [127:0] tlb_entry_t;

    // array geometry
    localparam int TLB_WAYS = 2;
    localparam int TLB_SETS = 8;

    // page size codes
    localparam logic [2:0] PAGE_4K = 3'd0;
    localparam logic [2:0] PAGE_2M = 3'd1;
    localparam logic [2:0] PAGE_1G = 3'd2;

    // ************************************************************
    // sv39 pte fields
    // ************************************************************
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_G       = 5;
    localparam int PTE_A       = 6;
    localparam int PTE_PPN_LSB = 10;

    // entry fields
    localparam int ENTRY_VPN_LSB  = 31;
    localparam int ENTRY_ATTR_LSB = 58;
    localparam int ENTRY_ASID_LSB = 112;
    localparam int ENTRY_G_BIT    = ENTRY_ATTR_LSB + PTE_G;

    typedef enum logic [2:0] {
        IDLE,
        SEARCH,
        WALK_L2,
        WALK_L1,
        WALK_L0,
        RESPOND
    } walk_state_t;

endpackage

`default_nettype wire
